//--- include/eth_tx_config.svh
//**************************************************************************
// queue depths for the frame transmitter
// both depths are entry counts and must be at least 1
//**************************************************************************
`ifndef ETH_TX_CFG_SVH
`define ETH_TX_CFG_SVH

// headers that may wait ahead of their payload
`define ETH_TX_HDR_DEPTH 4

// payload bytes buffered between input and framer
`define ETH_TX_PAY_DEPTH 32

`endif

//--- src/eth_tx_pkg.sv
//**************************************************************************
// shared types for the frame transmitter
// header struct packs dest mac into the top bits, so byte 0 is its msb
//**************************************************************************
`default_nettype none

package eth_tx_pkg;

    // header fields in wire order, msb first
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // one payload beat as stored in the queue
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } axis_beat_t;

    // dest + src + ethertype, no vlan tag
    localparam int ETH_HDR_BYTES = 14;

endpackage

`default_nettype wire

//--- src/axis_byte_if.sv
//**************************************************************************
// byte-wide valid/ready stream
// a beat moves on a rising edge with tvalid and tready both high
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

interface axis_byte_if;

    logic [7:0] tdata;
    logic       tvalid;
    logic       tready;
    logic       tlast;
    logic       tuser;

    // producer side
    modport src (output tdata, output tvalid, output tlast, output tuser,
                 input tready);

    // consumer side
    modport snk (input tdata, input tvalid, input tlast, input tuser,
                 output tready);

endinterface

`default_nettype wire

//--- src/stream_fifo.sv
//**************************************************************************
// synchronous queue with valid/ready on both sides
// read data comes straight from the array, no output register
// a full queue does not accept a write even when a read happens
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 4
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   wr_valid,
    output logic   wr_ready,
    input  entry_t wr_data,
    output logic   rd_valid,
    input  logic   rd_ready,
    output entry_t rd_data
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);
    localparam logic [CW-1:0] FULL_CNT = CW'(DEPTH);

    entry_t        mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    assign wr_ready = (count != FULL_CNT);
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];

    assign push = wr_valid & wr_ready;
    assign pop  = rd_valid & rd_ready;

    // storage array, contents only matter below count
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at DEPTH, not at a power of two
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/eth_frame_tx.sv
//**************************************************************************
// framer: 14 header bytes msb first, then the payload until tlast
// output is combinational, a register stage must follow
// a payload beat without a matching header waits forever
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module eth_frame_tx
    import eth_tx_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     hdr_valid,
    output logic     hdr_ready,
    input  eth_hdr_t hdr,
    axis_byte_if.snk pay,
    axis_byte_if.src out,
    output logic     busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR,
        ST_PAY
    } state_t;

    localparam logic [3:0] LAST_IDX = 4'(ETH_HDR_BYTES - 1);

    state_t     state;
    eth_hdr_t   hdr_q;
    logic [3:0] byte_idx;

    // byte view of the latched header, index 13 is dest_mac[47:40]
    logic [ETH_HDR_BYTES-1:0][7:0] hdr_bytes;

    assign hdr_bytes = hdr_q;

    // pop only from idle
    assign hdr_ready = (state == ST_IDLE);
    assign busy      = (state != ST_IDLE);

    // header latched on the pop edge
    always_ff @(posedge clk) begin
        if (hdr_valid && hdr_ready) begin
            hdr_q <= hdr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            byte_idx <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    byte_idx <= '0;
                    if (hdr_valid) begin
                        state <= ST_HDR;
                    end
                end
                ST_HDR: begin
                    // advance one byte per accepted beat
                    if (out.tready) begin
                        if (byte_idx == LAST_IDX) begin
                            state <= ST_PAY;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                ST_PAY: begin
                    // frame ends on the tlast transfer
                    if (pay.tvalid && out.tready && pay.tlast) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        out.tvalid = 1'b0;
        out.tdata  = 8'h00;
        out.tlast  = 1'b0;
        out.tuser  = 1'b0;
        pay.tready = 1'b0;
        case (state)
            ST_HDR: begin
                // header beats never carry last or user
                out.tvalid = 1'b1;
                out.tdata  = hdr_bytes[LAST_IDX - byte_idx];
            end
            ST_PAY: begin
                // payload passes straight through
                out.tvalid = pay.tvalid;
                out.tdata  = pay.tdata;
                out.tlast  = pay.tlast;
                out.tuser  = pay.tuser;
                pay.tready = out.tready;
            end
            default: begin
                out.tvalid = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/axis_skid_buf.sv
//**************************************************************************
// two-entry skid buffer, full throughput under back-pressure
// input ready is registered, it drops only while the spare slot holds data
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buf
    import eth_tx_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    axis_byte_if.snk in,
    axis_byte_if.src out
);

    axis_beat_t in_beat;
    axis_beat_t out_q;
    axis_beat_t tmp_q;
    logic       out_valid;
    logic       tmp_valid;
    logic       out_free;

    assign in_beat = '{data: in.tdata, last: in.tlast, user: in.tuser};

    // output slot can load this edge
    assign out_free = ~out_valid | out.tready;

    // spare slot empty means ready, both flops
    assign in.tready = ~tmp_valid;

    assign out.tvalid = out_valid;
    assign out.tdata  = out_q.data;
    assign out.tlast  = out_q.last;
    assign out.tuser  = out_q.user;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            tmp_valid <= 1'b0;
        end else if (tmp_valid) begin
            // drain spare slot first, input is held off meanwhile
            if (out_free) begin
                out_valid <= 1'b1;
                tmp_valid <= 1'b0;
            end
        end else if (out_free) begin
            out_valid <= in.tvalid;
        end else if (in.tvalid) begin
            // output stalled, park the one extra beat
            tmp_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_q <= tmp_valid ? tmp_q : in_beat;
        end
        if (!tmp_valid && !out_free) begin
            tmp_q <= in_beat;
        end
    end

endmodule

`default_nettype wire

//--- src/eth_tx_top.sv
//**************************************************************************
// ethernet frame transmitter top, header queue + payload queue + framer
// no preamble, fcs, padding or vlan, payload needs tlast on every frame
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "eth_tx_config.svh"

module eth_tx_top
    import eth_tx_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_hdr_valid,
    output logic        in_hdr_ready,
    input  logic [47:0] in_dest_mac,
    input  logic [47:0] in_src_mac,
    input  logic [15:0] in_eth_type,
    input  logic [7:0]  in_pay_tdata,
    input  logic        in_pay_tvalid,
    output logic        in_pay_tready,
    input  logic        in_pay_tlast,
    input  logic        in_pay_tuser,
    output logic [7:0]  out_tdata,
    output logic        out_tvalid,
    input  logic        out_tready,
    output logic        out_tlast,
    output logic        out_tuser,
    output logic        busy
);

    eth_hdr_t   hdr_wr;
    eth_hdr_t   hdr_rd;
    logic       hdr_rd_valid;
    logic       hdr_rd_ready;
    axis_beat_t pay_wr;
    axis_beat_t pay_rd;

    axis_byte_if pay_q ();
    axis_byte_if fr_out ();
    axis_byte_if sk_out ();

    assign hdr_wr = '{dest_mac: in_dest_mac, src_mac: in_src_mac, eth_type: in_eth_type};
    assign pay_wr = '{data: in_pay_tdata, last: in_pay_tlast, user: in_pay_tuser};

    stream_fifo #(.entry_t(eth_hdr_t), .DEPTH(`ETH_TX_HDR_DEPTH)) u_hdr_fifo (
        .clk(clk), .rst(rst),
        .wr_valid(in_hdr_valid), .wr_ready(in_hdr_ready), .wr_data(hdr_wr),
        .rd_valid(hdr_rd_valid), .rd_ready(hdr_rd_ready), .rd_data(hdr_rd)
    );

    stream_fifo #(.entry_t(axis_beat_t), .DEPTH(`ETH_TX_PAY_DEPTH)) u_pay_fifo (
        .clk(clk), .rst(rst),
        .wr_valid(in_pay_tvalid), .wr_ready(in_pay_tready), .wr_data(pay_wr),
        .rd_valid(pay_q.tvalid), .rd_ready(pay_q.tready), .rd_data(pay_rd)
    );

    // queue entry onto the framer's payload stream
    assign pay_q.tdata = pay_rd.data;
    assign pay_q.tlast = pay_rd.last;
    assign pay_q.tuser = pay_rd.user;

    eth_frame_tx u_framer (
        .clk(clk), .rst(rst),
        .hdr_valid(hdr_rd_valid), .hdr_ready(hdr_rd_ready), .hdr(hdr_rd),
        .pay(pay_q.snk), .out(fr_out.src), .busy(busy)
    );

    axis_skid_buf u_skid (
        .clk(clk), .rst(rst), .in(fr_out.snk), .out(sk_out.src)
    );

    assign out_tdata    = sk_out.tdata;
    assign out_tvalid   = sk_out.tvalid;
    assign out_tlast    = sk_out.tlast;
    assign out_tuser    = sk_out.tuser;
    assign sk_out.tready = out_tready;

endmodule

`default_nettype wire

//--- verif/eth_tx_checker.sv
//**************************************************************************
// output monitor, compares every transferred byte with the expected queue
// samples on the falling edge, inputs and outputs are settled there
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module eth_tx_checker (
    input logic       clk,
    input logic       rst,
    input logic [7:0] out_tdata,
    input logic       out_tvalid,
    input logic       out_tready,
    input logic       out_tlast,
    input logic       out_tuser,
    input logic       busy
);

    // {data, last, user} per expected byte
    logic [9:0] exp_q [$];
    logic [9:0] exp_beat;
    int         error_count = 0;
    int         beat_count = 0;

    // filled by the testbench before stimulus starts
    function automatic void expect_beat(input logic [7:0] data,
                                        input logic       last,
                                        input logic       user);
        exp_q.push_back({data, last, user});
    endfunction

    function automatic int missing_count();
        return exp_q.size();
    endfunction

    task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            error_count++;
            $display("ERROR time %0t: %s expected %02h, got %02h", $time, name, exp, act);
        end
    endtask

    // framer idle and nothing on the output
    task automatic check_idle();
        check_value("busy", 8'h00, 8'(busy));
        check_value("out_tvalid", 8'h00, 8'(out_tvalid));
    endtask

    // valid and ready high here means a transfer on the next rising edge
    always @(negedge clk) begin
        if (!rst && out_tvalid && out_tready) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("extra output byte %02h at time %0t, nothing was expected",
                         out_tdata, $time);
            end else begin
                exp_beat = exp_q.pop_front();
                check_value("out_tdata", exp_beat[9:2], out_tdata);
                check_value("out_tlast", 8'(exp_beat[1]), 8'(out_tlast));
                check_value("out_tuser", 8'(exp_beat[0]), 8'(out_tuser));
                beat_count++;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_eth_tx.sv
//**************************************************************************
// frame transmitter testbench, frames come from verif/eth_tx_cases.txt
// headers are pushed ahead of payloads, so several frames queue up
// must run from the project root for the relative cases path
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_eth_tx;

    localparam string CASES_FILE    = "verif/eth_tx_cases.txt";
    localparam int    HDR_BYTES     = 14;
    localparam int    CYCLES_PER_BYTE = 40;
    localparam int    MARGIN_CYCLES = 500;

    logic        clk;
    logic        rst;
    logic        in_hdr_valid;
    logic        in_hdr_ready;
    logic [47:0] in_dest_mac;
    logic [47:0] in_src_mac;
    logic [15:0] in_eth_type;
    logic [7:0]  in_pay_tdata;
    logic        in_pay_tvalid;
    logic        in_pay_tready;
    logic        in_pay_tlast;
    logic        in_pay_tuser;
    logic [7:0]  out_tdata;
    logic        out_tvalid;
    logic        out_tready;
    logic        out_tlast;
    logic        out_tuser;
    logic        busy;

    // one entry per frame line
    logic [47:0] c_dest [$];
    logic [47:0] c_src [$];
    logic [15:0] c_type [$];
    int          c_len [$];
    logic [7:0]  c_start [$];
    logic        c_err [$];
    logic        c_bp [$];

    logic [31:0] rnd_state;
    logic        bp_random = 1'b0;
    int          limit_cycles = 0;

    eth_tx_top u_eth_tx_top (.*);

    eth_tx_checker u_checker (
        .clk(clk), .rst(rst),
        .out_tdata(out_tdata), .out_tvalid(out_tvalid), .out_tready(out_tready),
        .out_tlast(out_tlast), .out_tuser(out_tuser), .busy(busy)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // reads the frames and builds the expected byte stream
    function automatic int load_cases();
        int          fd;
        int          n;
        int          len;
        int          err;
        int          bp;
        string       line;
        logic [47:0] d;
        logic [47:0] s;
        logic [15:0] t;
        logic [7:0]  st;
        logic [111:0] hdr;
        int          total;
        total = 0;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s", CASES_FILE);
            return 0;
        end
        while ($fgets(line, fd) != 0) begin
            // comment lines start with #
            if (line.len() == 0 || line[0] == 8'h23) begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %d %h %d %d", d, s, t, len, st, err, bp);
            if (n < 7 || len < 1) begin
                continue;
            end
            c_dest.push_back(d);
            c_src.push_back(s);
            c_type.push_back(t);
            c_len.push_back(len);
            c_start.push_back(st);
            c_err.push_back(err != 0);
            c_bp.push_back(bp != 0);
            // header goes out dest, src, type, each msb first
            hdr = {d, s, t};
            for (int k = 0; k < HDR_BYTES; k++) begin
                u_checker.expect_beat(hdr[111 - 8*k -: 8], 1'b0, 1'b0);
            end
            // payload counts up from the start byte, wraps at 8 bits
            for (int k = 0; k < len; k++) begin
                u_checker.expect_beat(st + 8'(k), k == len - 1,
                                      (err != 0) && (k == len - 1));
            end
            total += HDR_BYTES + len;
        end
        $fclose(fd);
        return total;
    endfunction

    // call with inputs just driven after a rising edge
    task automatic wait_transfer(input bit hdr_side);
        bit taken;
        do begin
            @(negedge clk);
            taken = hdr_side ? in_hdr_ready : in_pay_tready;
            @(posedge clk);
            #1;
        end while (!taken);
    endtask

    task automatic drive_headers();
        for (int i = 0; i < c_len.size(); i++) begin
            in_hdr_valid = 1'b1;
            in_dest_mac  = c_dest[i];
            in_src_mac   = c_src[i];
            in_eth_type  = c_type[i];
            wait_transfer(1'b1);
        end
        in_hdr_valid = 1'b0;
    endtask

    task automatic drive_payloads();
        for (int i = 0; i < c_len.size(); i++) begin
            bp_random = c_bp[i];
            for (int k = 0; k < c_len[i]; k++) begin
                in_pay_tvalid = 1'b1;
                in_pay_tdata  = c_start[i] + 8'(k);
                in_pay_tlast  = (k == c_len[i] - 1);
                in_pay_tuser  = c_err[i] && (k == c_len[i] - 1);
                wait_transfer(1'b0);
            end
        end
        in_pay_tvalid = 1'b0;
        in_pay_tlast  = 1'b0;
        in_pay_tuser  = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // sink ready, held high or random per frame
    initial begin
        out_tready = 1'b1;
        rnd_state  = 32'ha2f315b9;
        forever begin
            @(posedge clk);
            #1;
            rnd_state  = xorshift32(rnd_state);
            out_tready = bp_random ? rnd_state[0] : 1'b1;
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timed out after %0d cycles with output bytes still outstanding",
                 limit_cycles);
        $display("errors: %0d, bytes missing: %0d",
                 u_checker.error_count, u_checker.missing_count());
        $display("sim failed");
        $finish;
    end

    initial begin
        int total;
        rst           = 1'b1;
        in_hdr_valid  = 1'b0;
        in_dest_mac   = '0;
        in_src_mac    = '0;
        in_eth_type   = '0;
        in_pay_tdata  = '0;
        in_pay_tvalid = 1'b0;
        in_pay_tlast  = 1'b0;
        in_pay_tuser  = 1'b0;
        total = load_cases();
        if (total == 0) begin
            $display("no frames could be read from the cases file");
            $display("sim failed");
            $finish;
        end else begin
            limit_cycles = CYCLES_PER_BYTE * total + MARGIN_CYCLES;
            repeat (3) @(posedge clk);
            #1;
            rst = 1'b0;
            @(negedge clk);
            u_checker.check_idle();
            @(posedge clk);
            #1;
            fork
                drive_headers();
                drive_payloads();
            join
            while (u_checker.missing_count() != 0) begin
                @(negedge clk);
            end
            // framer idle and skid buffer empty once drained
            repeat (4) @(negedge clk);
            u_checker.check_idle();
            $display("errors: %0d, bytes checked: %0d, bytes missing: %0d",
                     u_checker.error_count, u_checker.beat_count,
                     u_checker.missing_count());
            if (u_checker.error_count == 0 && u_checker.missing_count() == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
src/eth_tx_pkg.sv
src/axis_byte_if.sv
src/stream_fifo.sv
src/eth_frame_tx.sv
src/axis_skid_buf.sv
src/eth_tx_top.sv
verif/eth_tx_checker.sv
verif/tb_eth_tx.sv

//--- Makefile
# Verilator build and run for the Ethernet frame transmitter testbench.
# Run from the project root, the testbench reads verif/eth_tx_cases.txt.

VERILATOR ?= verilator
TOP       ?= tb_eth_tx
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= sim passed

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard src/*.sv verif/*.sv include/*.svh)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

# status comes from the pass line in the simulator output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/eth_tx_cases.txt
# dest_mac(hex) src_mac(hex) eth_type(hex) pay_len(dec) pay_start(hex) err(0/1) bp(0 ready high, 1 random)
# one frame per line, payload byte k is pay_start + k
ffffffffffff 0123456789ab 0806 1 00 0 0
0123456789ab 02aabbccddee 0800 5 10 0 0
02aabbccddee 0123456789ab 86dd 46 f0 1 0
001122334455 66778899aabb 0800 60 c8 0 0
a1b2c3d4e5f6 0f1e2d3c4b5a 88b5 3 fe 1 1
0f1e2d3c4b5a a1b2c3d4e5f6 0800 2 7f 0 1
deadbeef0001 cafef00d0002 0806 40 20 0 1
112233445566 778899aabbcc 0800 100 01 1 1
5a5a5a5a5a5a a5a5a5a5a5a5 88cc 8 80 0 0
010203040506 0a0b0c0d0e0f 86dd 14 ee 1 1
fedcba987654 123456789abc 0800 33 40 0 1
000000000001 800000000000 0801 1 ff 1 1
